//--- logic/spis_cmd_pkg.sv
// Opcode values and frame engine states for the SPI slave command word

package spis_cmd_pkg;

	// Width of the opcode field in bits 31..24 of the command word
	typedef logic [7:0] opcode_t;

	// Number of data words in one transfer
	typedef logic [7:0] burst_len_t;

	localparam opcode_t OP_SINGLE_RD = 8'h00;
	localparam opcode_t OP_SINGLE_WR = 8'h01;
	localparam opcode_t OP_BURST_RD  = 8'h20;
	localparam opcode_t OP_BURST_WR  = 8'h21;

	// Frame engine FSM
	typedef enum logic [2:0] {
		ST_IDLE,      // Waiting for the first edge with ss_n low
		ST_CMD,       // Shifting in the command word
		ST_WR_WAIT,   // Shifting in a write data word
		ST_WR_ISSUE,  // Write strobe cycle
		ST_RD_WAIT,   // Waiting for bit 28 of the current slot
		ST_RD_ISSUE,  // Read strobe taken
		ST_DONE       // Transfer finished or ignored
	} frame_state_t;

endpackage

//--- logic/spis_bus_pkg.sv
// Register side types and addresses shared by the frame engine and the register bank

package spis_bus_pkg;

	// Register address, as carried in bits 15..0 of the command word
	typedef logic [15:0] addr_t;

	// One register word
	typedef logic [31:0] data_t;

	// Write request from the frame engine, 48 bits
	typedef struct packed {
		addr_t addr;
		data_t data;
	} wr_req_t;

	// Read request, data comes back in the same cycle
	typedef struct packed {
		addr_t addr;
	} rd_req_t;

	// Read-only count of completed frames
	// Sits above the largest general register range
	localparam addr_t FRAME_CNT_ADDR = 16'h0100;

endpackage

//--- logic/spis_frame.sv
// SPI mode 0 only, and sclk has to keep toggling while ss_n is high to clear the frame state

`timescale 1ns/1ps

module spis_frame (
	input  logic                   sclk,
	input  logic                   rst_n,
	input  logic                   ss_n,
	input  logic                   mosi,
	input  spis_bus_pkg::data_t    rd_data,
	output logic                   miso,
	output logic                   wr_en,
	output logic                   rd_en,
	output logic                   frame_end,
	output spis_bus_pkg::wr_req_t  wr_req,
	output spis_bus_pkg::rd_req_t  rd_req
);

	logic [4:0]                   bit_cnt;     // Bit position within the current word
	logic                         last_bit;    // Edge that completes a word
	logic                         word_done;   // High the cycle after a word completes
	logic                         word_seen;   // At least one full word in this frame
	logic                         ss_q;        // ss_n as seen on the previous edge
	spis_bus_pkg::data_t          rx_shift;
	spis_bus_pkg::data_t          rx_word;     // Shift register including the current bit

	spis_cmd_pkg::opcode_t        op;
	logic                         op_rd;
	logic                         op_wr;
	spis_cmd_pkg::burst_len_t     op_len;

	spis_cmd_pkg::frame_state_t   state;
	spis_cmd_pkg::frame_state_t   state_nxt;
	spis_cmd_pkg::burst_len_t     burst_cnt;   // Requests still to issue
	spis_bus_pkg::addr_t          cur_addr;

	spis_bus_pkg::data_t          tx_hold;     // Read data waiting for the next slot
	spis_bus_pkg::data_t          tx_shift;

	//////////////////////////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////////////////////////

	assign last_bit = (bit_cnt == 5'd31);
	assign rx_word  = {rx_shift[30:0], mosi};

	always_ff @(posedge sclk) begin
		if (!ss_n)
			rx_shift <= rx_word;
	end

	// Opcode decode, looks at the word as it completes
	always_comb begin
		op     = rx_word[31:24];
		op_rd  = 1'b0;
		op_wr  = 1'b0;
		op_len = rx_word[23:16];
		case (op)
			spis_cmd_pkg::OP_SINGLE_RD: begin
				op_rd  = 1'b1;
				op_len = 8'd1;
			end
			spis_cmd_pkg::OP_SINGLE_WR: begin
				op_wr  = 1'b1;
				op_len = 8'd1;
			end
			spis_cmd_pkg::OP_BURST_RD: op_rd = 1'b1;
			spis_cmd_pkg::OP_BURST_WR: op_wr = 1'b1;
			default:                   op_len = '0;    // Unknown opcode
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			spis_cmd_pkg::ST_IDLE: state_nxt = spis_cmd_pkg::ST_CMD;
			spis_cmd_pkg::ST_CMD: begin
				if (last_bit) begin
					if (op_len == '0)
						state_nxt = spis_cmd_pkg::ST_DONE;    // Empty burst or bad opcode
					else if (op_wr)
						state_nxt = spis_cmd_pkg::ST_WR_WAIT;
					else if (op_rd)
						state_nxt = spis_cmd_pkg::ST_RD_WAIT;
					else
						state_nxt = spis_cmd_pkg::ST_DONE;
				end
			end
			spis_cmd_pkg::ST_WR_WAIT: begin
				if (last_bit)
					state_nxt = spis_cmd_pkg::ST_WR_ISSUE;
			end
			spis_cmd_pkg::ST_WR_ISSUE: begin
				state_nxt = (burst_cnt == 8'd1) ? spis_cmd_pkg::ST_DONE
				                                : spis_cmd_pkg::ST_WR_WAIT;
			end
			spis_cmd_pkg::ST_RD_WAIT: begin
				if (bit_cnt == 5'd28)
					state_nxt = spis_cmd_pkg::ST_RD_ISSUE;
			end
			spis_cmd_pkg::ST_RD_ISSUE: begin
				state_nxt = (burst_cnt == 8'd1) ? spis_cmd_pkg::ST_DONE
				                                : spis_cmd_pkg::ST_RD_WAIT;
			end
			spis_cmd_pkg::ST_DONE: state_nxt = spis_cmd_pkg::ST_DONE;    // Extra words ignored
			default:               state_nxt = spis_cmd_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n)
			state <= spis_cmd_pkg::ST_IDLE;
		else if (ss_n)
			state <= spis_cmd_pkg::ST_IDLE;    // Abort or end of frame
		else
			state <= state_nxt;
	end

	// Bit counting, burst sequencing and the write strobe
	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= '0;
			word_done <= 1'b0;
			word_seen <= 1'b0;
			burst_cnt <= '0;
			cur_addr  <= '0;
			wr_en     <= 1'b0;
		end else if (ss_n) begin
			bit_cnt   <= '0;
			word_done <= 1'b0;
			word_seen <= 1'b0;
			burst_cnt <= '0;
			cur_addr  <= '0;
			wr_en     <= 1'b0;
		end else begin
			bit_cnt   <= bit_cnt + 5'd1;
			word_done <= last_bit;
			if (last_bit)
				word_seen <= 1'b1;
			wr_en <= (state == spis_cmd_pkg::ST_WR_WAIT) && last_bit;
			case (state)
				spis_cmd_pkg::ST_CMD: begin
					if (last_bit) begin
						burst_cnt <= op_len;
						cur_addr  <= rx_word[15:0];
					end
				end
				spis_cmd_pkg::ST_WR_ISSUE, spis_cmd_pkg::ST_RD_ISSUE: begin
					burst_cnt <= burst_cnt - 8'd1;
					cur_addr  <= cur_addr + 16'd1;    // Next element of the burst
				end
				default: ;
			endcase
		end
	end

	// Write payload, held until the next data word completes
	always_ff @(posedge sclk) begin
		if (!ss_n && (state == spis_cmd_pkg::ST_WR_WAIT) && last_bit)
			wr_req <= '{addr: cur_addr, data: rx_word};
	end

	// Read strobe at bit 28, the bank answers in the same cycle
	assign rd_en  = (state == spis_cmd_pkg::ST_RD_WAIT) && (bit_cnt == 5'd28);
	assign rd_req = '{addr: cur_addr};

	// One pulse per frame that held a full word
	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			ss_q      <= 1'b1;
			frame_end <= 1'b0;
		end else begin
			ss_q      <= ss_n;
			frame_end <= ss_n && !ss_q && word_seen;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n)
			tx_hold <= '0;
		else if (ss_n)
			tx_hold <= '0;
		else if (rd_en)
			tx_hold <= rd_data;
		else if (word_done)
			tx_hold <= '0;    // Already loaded, slots without a read send zeros
	end

	// Launch on the falling edge, MSB first
	always_ff @(negedge sclk or negedge rst_n) begin
		if (!rst_n)
			tx_shift <= '0;
		else if (ss_n)
			tx_shift <= '0;
		else if (word_done)
			tx_shift <= tx_hold;    // Falling edge that opens the next slot
		else
			tx_shift <= {tx_shift[30:0], 1'b0};
	end

	assign miso = tx_shift[31];

endmodule

//--- logic/spis_reg_bank.sv
// REG_COUNT from 1 to 256 so the general registers never reach the frame counter address

`timescale 1ns/1ps

module spis_reg_bank #(
	parameter int REG_COUNT = 16
) (
	input  logic                   sclk,
	input  logic                   rst_n,
	input  logic                   wr_en,
	input  logic                   rd_en,
	input  logic                   frame_end,
	input  spis_bus_pkg::wr_req_t  wr_req,
	input  spis_bus_pkg::rd_req_t  rd_req,
	output spis_bus_pkg::data_t    rd_data
);

	// Index width, kept at one bit for a single register
	localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

	spis_bus_pkg::data_t  regs [REG_COUNT];
	spis_bus_pkg::data_t  frame_cnt;
	logic                 wr_hit;    // Write lands in a general register
	logic                 rd_hit;

	assign wr_hit = (wr_req.addr < spis_bus_pkg::addr_t'(REG_COUNT));
	assign rd_hit = (rd_req.addr < spis_bus_pkg::addr_t'(REG_COUNT));

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Counter address and unmapped addresses drop the write
	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_hit) begin
			regs[wr_req.addr[IDX_W-1:0]] <= wr_req.data;
		end
	end

	always_ff @(posedge sclk or negedge rst_n) begin
		if (!rst_n)
			frame_cnt <= '0;
		else if (frame_end)
			frame_cnt <= frame_cnt + 32'd1;    // Wraps after 2^32 frames
	end

	//////////////////////////////////////////////////////////////////////
	// Read decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_data = '0;    // Unmapped addresses read as zero
		if (rd_en) begin
			if (rd_req.addr == spis_bus_pkg::FRAME_CNT_ADDR)
				rd_data = frame_cnt;
			else if (rd_hit)
				rd_data = regs[rd_req.addr[IDX_W-1:0]];
		end
	end

endmodule

//--- logic/spis_top.sv
// SPI mode 0 register slave clocked only by sclk, with REG_COUNT valid from 1 to 256

`timescale 1ns/1ps

module spis_top #(
	parameter int REG_COUNT = 16
) (
	input  logic  sclk,
	input  logic  rst_n,
	input  logic  ss_n,
	input  logic  mosi,
	output logic  miso
);

	// Frame engine to register bank strobes
	logic                   wr_en;
	logic                   rd_en;
	logic                   frame_end;
	spis_bus_pkg::wr_req_t  wr_req;
	spis_bus_pkg::rd_req_t  rd_req;
	spis_bus_pkg::data_t    rd_data;

	spis_frame u_frame (
		.sclk      (sclk),
		.rst_n     (rst_n),
		.ss_n      (ss_n),
		.mosi      (mosi),
		.rd_data   (rd_data),
		.miso      (miso),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.frame_end (frame_end),
		.wr_req    (wr_req),
		.rd_req    (rd_req)
	);

	spis_reg_bank #(
		.REG_COUNT (REG_COUNT)
	) u_bank (
		.sclk      (sclk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.rd_en     (rd_en),
		.frame_end (frame_end),
		.wr_req    (wr_req),
		.rd_req    (rd_req),
		.rd_data   (rd_data)
	);

endmodule

//--- verification/spis_properties.sv
// Frame engine checks bound into every spis_frame, idle while rst_n is low

`timescale 1ns/1ps

module spis_properties (
	input logic                        sclk,
	input logic                        rst_n,
	input logic                        ss_n,
	input logic                        wr_en,
	input logic                        rd_en,
	input spis_cmd_pkg::frame_state_t  state
);

	// The bank takes one request per cycle
	a_one_strobe: assert property (@(posedge sclk) disable iff (!rst_n) !(wr_en && rd_en))
		else $error("wr_en and rd_en high in the same cycle");

	a_wr_pulse: assert property (@(posedge sclk) disable iff (!rst_n) wr_en |=> !wr_en)
		else $error("wr_en held high for more than one cycle");

	a_rd_pulse: assert property (@(posedge sclk) disable iff (!rst_n) rd_en |=> !rd_en)
		else $error("rd_en held high for more than one cycle");

	// ss_n high ends or aborts the frame
	a_idle_after_ss: assert property (@(posedge sclk) disable iff (!rst_n)
		ss_n |=> (state == spis_cmd_pkg::ST_IDLE))
		else $error("frame FSM not idle after ss_n was seen high");

endmodule

bind spis_frame spis_properties u_props (
	.sclk  (sclk),
	.rst_n (rst_n),
	.ss_n  (ss_n),
	.wr_en (wr_en),
	.rd_en (rd_en),
	.state (state)
);

//--- verification/spis_tb.sv
// Runs spis_top at REG_COUNT 16 through a table of SPI mode 0 frames with one transaction per frame

`timescale 1ns/1ps

module spis_tb;

	localparam int REG_COUNT = 16;
	localparam int NUM_ROWS  = 13;
	localparam int MAX_WORDS = 6;    // Command, turnaround and a burst of 4

	// One transaction of the table
	typedef struct packed {
		logic [7:0]  op;
		logic [7:0]  len;
		logic [15:0] addr;
		logic [15:0] abort_bits;    // Nonzero raises ss_n after this many bits
	} row_t;

	logic         sclk;
	logic         rst_n;
	logic         ss_n;
	logic         mosi;
	logic         miso;

	row_t         rows [NUM_ROWS];
	logic [31:0]  tx_words [MAX_WORDS];
	logic [31:0]  rx_words [MAX_WORDS];
	logic [31:0]  shadow [REG_COUNT];    // Expected general register contents
	int           frames_done;           // Frames that held at least one full word
	int           seed;
	int           checks;
	int           mismatches;
	int           timeouts;

	spis_top #(
		.REG_COUNT (REG_COUNT)
	) u_dut (
		.sclk  (sclk),
		.rst_n (rst_n),
		.ss_n  (ss_n),
		.mosi  (mosi),
		.miso  (miso)
	);

	initial begin
		sclk = 1'b0;
		forever #5 sclk = ~sclk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge sclk);
		#1 rst_n = 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Data words moved by an opcode and zero for unknown ones
	function automatic logic [7:0] eff_len(input logic [7:0] op, input logic [7:0] len);
		case (op)
			spis_cmd_pkg::OP_SINGLE_RD, spis_cmd_pkg::OP_SINGLE_WR: return 8'd1;
			spis_cmd_pkg::OP_BURST_RD, spis_cmd_pkg::OP_BURST_WR:   return len;
			default:                                                return 8'd0;
		endcase
	endfunction

	function automatic logic is_read(input logic [7:0] op);
		return (op == spis_cmd_pkg::OP_SINGLE_RD) || (op == spis_cmd_pkg::OP_BURST_RD);
	endfunction

	function automatic logic [31:0] model_read(input logic [15:0] addr);
		if (addr == spis_bus_pkg::FRAME_CNT_ADDR)
			return 32'(frames_done);
		else if (addr < 16'(REG_COUNT))
			return shadow[addr[3:0]];
		return 32'h0;    // Unmapped
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Frame driver and row check
	//////////////////////////////////////////////////////////////////////

	task automatic drive_frame(input int nbits);
		@(posedge sclk);
		#1;
		for (int n = 0; n < nbits; n++) begin
			mosi = tx_words[n / 32][31 - (n % 32)];    // MSB first
			ss_n = 1'b0;
			@(posedge sclk);
			rx_words[n / 32][31 - (n % 32)] = miso;
			#1;
		end
		ss_n = 1'b1;
		mosi = 1'b0;
	endtask

	task automatic apply_row(input int r);
		logic [7:0]  len;
		logic [15:0] addr;
		logic [31:0] exp_word;
		logic        rd;
		int          nwords;
		int          nbits;
		int          cyc;
		len = eff_len(rows[r].op, rows[r].len);
		rd  = is_read(rows[r].op);
		tx_words[0] = {rows[r].op, rows[r].len, rows[r].addr};
		rx_words[0] = 32'h0;
		for (int w = 1; w < MAX_WORDS; w++) begin
			tx_words[w] = rd ? 32'h0 : $random(seed);
			rx_words[w] = 32'h0;
		end
		if (rd)
			nwords = 2 + int'(len);
		else if (len != 0)
			nwords = 1 + int'(len);
		else
			nwords = MAX_WORDS;    // Unknown opcode still sends a full frame
		nbits = (rows[r].abort_bits != 0) ? int'(rows[r].abort_bits) : 32 * nwords;
		drive_frame(nbits);

		cyc = 0;
		while (u_dut.frame_end !== 1'b1 && cyc < 10) begin
			@(posedge sclk);
			#1;
			cyc++;
		end
		if (u_dut.frame_end !== 1'b1) begin
			$display("Timeout: row %0d saw no frame_end pulse after ss_n went high", r);
			timeouts++;
		end

		// Slot 1 is turnaround and element i sits in slot i+2
		for (int s = 1; s < (nbits + 31) / 32; s++) begin
			exp_word = 32'h0;
			if (rd && s >= 2 && (s - 2) < int'(len))
				exp_word = model_read(rows[r].addr + 16'(s - 2));
			checks++;
			if (rx_words[s] !== exp_word) begin
				$display("ERR %0t: row %0d slot %0d got %08h expected %08h",
				         $time, r, s, rx_words[s], exp_word);
				mismatches++;
			end
		end

		// Only data words that completed before ss_n rose are written
		if (!rd && len != 0) begin
			for (int i = 0; i < int'(len) && i < nbits / 32 - 1; i++) begin
				addr = rows[r].addr + 16'(i);
				if (addr < 16'(REG_COUNT))
					shadow[addr[3:0]] = tx_words[i + 1];
			end
		end
		if (nbits >= 32)
			frames_done++;
		repeat (2) @(posedge sclk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int cyc;
		ss_n        = 1'b1;
		mosi        = 1'b0;
		seed        = 32'h959c;
		frames_done = 0;
		checks      = 0;
		mismatches  = 0;
		timeouts    = 0;
		for (int i = 0; i < REG_COUNT; i++)
			shadow[i] = 32'h0;

		rows[0]  = '{spis_cmd_pkg::OP_SINGLE_WR, 8'd0, 16'h0003, 16'd0};
		rows[1]  = '{spis_cmd_pkg::OP_SINGLE_RD, 8'd0, 16'h0003, 16'd0};
		rows[2]  = '{spis_cmd_pkg::OP_BURST_WR, 8'd4, 16'h0008, 16'd0};
		rows[3]  = '{spis_cmd_pkg::OP_BURST_RD, 8'd4, 16'h0008, 16'd0};
		rows[4]  = '{spis_cmd_pkg::OP_SINGLE_WR, 8'd0, 16'h0010, 16'd0};    // First unmapped
		rows[5]  = '{spis_cmd_pkg::OP_SINGLE_RD, 8'd0, 16'h0010, 16'd0};
		rows[6]  = '{spis_cmd_pkg::OP_SINGLE_RD, 8'd0, 16'h0000, 16'd0};    // Same low bits as 0x10
		rows[7]  = '{spis_cmd_pkg::OP_SINGLE_RD, 8'd0, 16'h0100, 16'd0};    // Frame counter
		rows[8]  = '{8'h55, 8'd4, 16'h0008, 16'd0};
		rows[9]  = '{spis_cmd_pkg::OP_BURST_RD, 8'd4, 16'h0008, 16'd0};
		rows[10] = '{spis_cmd_pkg::OP_BURST_WR, 8'd4, 16'h0008, 16'd112};   // Mid word 3
		rows[11] = '{spis_cmd_pkg::OP_BURST_RD, 8'd4, 16'h0008, 16'd0};
		rows[12] = '{spis_cmd_pkg::OP_BURST_RD, 8'd2, 16'h00ff, 16'd0};     // Runs into counter

		cyc = 0;
		while (rst_n !== 1'b1 && cyc < 20) begin
			@(posedge sclk);
			cyc++;
		end
		if (rst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			timeouts++;
		end

		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(r);

		$display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- all.f
logic/spis_cmd_pkg.sv
logic/spis_bus_pkg.sv
logic/spis_frame.sv
logic/spis_reg_bank.sv
logic/spis_top.sv
verification/spis_properties.sv
verification/spis_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module spis_tb -f all.f -o spis_sim

sim_out=$(./obj_dir/spis_sim 2>&1)
echo "$sim_out"

if grep -q "^RESULT: PASS$" <<< "$sim_out"; then
	exit 0
fi
exit 1
